/* Bender.yml */
package:
  name: exec_stage

dependencies: {}

sources:
  - design/exec_pkg.sv
  - design/exec_dispatch.sv
  - design/alu_unit.sv
  - design/mul_unit.sv
  - design/wb_arbiter.sv
  - design/exec_top.sv
  - target: test
    files:
      - dv/exec_asserts.sv
      - dv/exec_tb.sv

/* design/alu_unit.sv */
// single-cycle integer ALU
// combinational datapath into one output register, val/rdy on both
// sides, accept overlaps drain so it sustains one op per cycle

`timescale 1ns/1ps

module alu_unit #(
  parameter int p_data_bits    = 32,
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      arst_n,

  // input side
  input  logic                      in_val,
  output logic                      in_rdy,
  input  logic [p_seq_num_bits-1:0] in_seq_num,
  input  logic [p_data_bits-1:0]    in_op1,
  input  logic [p_data_bits-1:0]    in_op2,
  input  logic [4:0]                in_waddr,
  input  exec_pkg::rv_uop           in_uop,

  // output side
  output logic                      out_val,
  input  logic                      out_rdy,
  output logic [p_seq_num_bits-1:0] out_seq_num,
  output logic [4:0]                out_waddr,
  output logic [p_data_bits-1:0]    out_wdata
);

  import exec_pkg::*;

  // shift amount width, log2 of the data width
  localparam int shamt_bits = $clog2(p_data_bits);

  logic [shamt_bits-1:0]  shamt;
  logic [p_data_bits-1:0] result;
  logic                   accept;

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  // only low bits of op2 count for shifts
  assign shamt = in_op2[shamt_bits-1:0];

  always_comb
  begin
    case (in_uop)
      op_add:  result = in_op1 + in_op2;
      op_sub:  result = in_op1 - in_op2;
      op_and:  result = in_op1 & in_op2;
      op_or:   result = in_op1 | in_op2;
      op_xor:  result = in_op1 ^ in_op2;
      op_sll:  result = in_op1 << shamt;
      op_srl:  result = in_op1 >> shamt;
      // sign bit fills from the left
      op_sra:  result = $signed(in_op1) >>> shamt;
      // signed compare
      op_slt:  result = {{(p_data_bits-1){1'b0}}, $signed(in_op1) < $signed(in_op2)};
      // unsigned compare
      op_sltu: result = {{(p_data_bits-1){1'b0}}, in_op1 < in_op2};
      // immediate already placed in op2
      op_lui:  result = in_op2;
      // op_mul never arrives here, unused codes give zero
      default: result = '0;
    endcase
  end

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------

  // free when empty or being drained this cycle
  assign in_rdy = !out_val || out_rdy;
  assign accept = in_val && in_rdy;

  // valid bit, reloaded whenever the slot turns over
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      out_val <= 1'b0;
    end
    else if (in_rdy)
    begin
      out_val <= in_val;
    end
  end

  // result payload, tag and destination travel together
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      out_seq_num <= in_seq_num;
      out_waddr   <= in_waddr;
      out_wdata   <= result;
    end
  end

endmodule

/* design/exec_dispatch.sv */
// execute stage dispatch
// steers each incoming micro-op to the ALU or the multiplier and
// returns that unit's ready as d_rdy, no storage

`timescale 1ns/1ps

module exec_dispatch (
  // D side handshake
  input  logic             d_val,
  input  exec_pkg::rv_uop  d_uop,
  output logic             d_rdy,

  // ALU side
  output logic             alu_in_val,
  input  logic             alu_in_rdy,

  // multiplier side
  output logic             mul_in_val,
  input  logic             mul_in_rdy
);

  import exec_pkg::*;

  // ------------------------------------------------------------
  // unit select
  // ------------------------------------------------------------

  // high when the micro-op belongs to the multiplier
  logic sel_mul;

  always_comb
  begin
    case (d_uop)
      op_mul:
      begin
        sel_mul = 1'b1;
      end
      // every other opcode, unused codes included, goes to the ALU
      default:
      begin
        sel_mul = 1'b0;
      end
    endcase
  end

  // ------------------------------------------------------------
  // handshake steering
  // ------------------------------------------------------------

  // valid only reaches the selected unit
  assign alu_in_val = d_val && !sel_mul;
  assign mul_in_val = d_val &&  sel_mul;

  // ready follows the unit this opcode is bound for
  // so a busy multiplier stalls only mul ops
  assign d_rdy = sel_mul ? mul_in_rdy : alu_in_rdy;

endmodule

/* design/exec_pkg.sv */
// execute stage shared definitions
// micro-op opcode encoding seen by dispatch, ALU and the testbench

package exec_pkg;

  // ------------------------------------------------------------
  // opcode width
  // ------------------------------------------------------------

  // four bits leave room for a few more ops later
  localparam int uop_bits = 4;

  // ------------------------------------------------------------
  // micro-op encoding
  // ------------------------------------------------------------

  typedef enum logic [uop_bits-1:0] {
    // arithmetic
    op_add  = 4'd0,
    op_sub  = 4'd1,

    // bitwise logic
    op_and  = 4'd2,
    op_or   = 4'd3,
    op_xor  = 4'd4,

    // shifts, amount from low bits of op2
    op_sll  = 4'd5,
    op_srl  = 4'd6,
    op_sra  = 4'd7,

    // set-less-than, result is 0 or 1
    op_slt  = 4'd8,
    op_sltu = 4'd9,

    // op2 already carries the shifted immediate
    op_lui  = 4'd10,

    // only opcode routed to the multiplier
    op_mul  = 4'd11
  } rv_uop;

  // codes 12..15 unused
  // the ALU returns zero for them

endpackage

/* design/exec_top.sv */
// execute stage top level
// dispatch, ALU, multiplier and writeback arbiter between the D and
// W val/rdy ports

`timescale 1ns/1ps

module exec_top #(
  parameter int p_data_bits    = 32,
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      arst_n,

  // D side, decoded micro-ops
  input  logic                      d_val,
  output logic                      d_rdy,
  input  logic [p_seq_num_bits-1:0] d_seq_num,
  input  logic [p_data_bits-1:0]    d_op1,
  input  logic [p_data_bits-1:0]    d_op2,
  input  logic [4:0]                d_waddr,
  input  exec_pkg::rv_uop           d_uop,

  // W side, results to writeback
  output logic                      w_val,
  input  logic                      w_rdy,
  output logic [p_seq_num_bits-1:0] w_seq_num,
  output logic [4:0]                w_waddr,
  output logic [p_data_bits-1:0]    w_wdata,
  output logic                      w_wen
);

  // ------------------------------------------------------------
  // internal wires
  // ------------------------------------------------------------

  // dispatch to units
  logic                      alu_in_val;
  logic                      alu_in_rdy;
  logic                      mul_in_val;
  logic                      mul_in_rdy;

  // ALU result
  logic                      alu_out_val;
  logic                      alu_out_rdy;
  logic [p_seq_num_bits-1:0] alu_out_seq_num;
  logic [4:0]                alu_out_waddr;
  logic [p_data_bits-1:0]    alu_out_wdata;

  // multiplier result
  logic                      mul_out_val;
  logic                      mul_out_rdy;
  logic [p_seq_num_bits-1:0] mul_out_seq_num;
  logic [4:0]                mul_out_waddr;
  logic [p_data_bits-1:0]    mul_out_wdata;

  // ------------------------------------------------------------
  // instances
  // ------------------------------------------------------------

  exec_dispatch dispatch0 (
    .d_val      (d_val),
    .d_uop      (d_uop),
    .d_rdy      (d_rdy),
    .alu_in_val (alu_in_val),
    .alu_in_rdy (alu_in_rdy),
    .mul_in_val (mul_in_val),
    .mul_in_rdy (mul_in_rdy)
  );

  // D payload fans out to both units
  alu_unit #(
    .p_data_bits    (p_data_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) alu0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_val      (alu_in_val),
    .in_rdy      (alu_in_rdy),
    .in_seq_num  (d_seq_num),
    .in_op1      (d_op1),
    .in_op2      (d_op2),
    .in_waddr    (d_waddr),
    .in_uop      (d_uop),
    .out_val     (alu_out_val),
    .out_rdy     (alu_out_rdy),
    .out_seq_num (alu_out_seq_num),
    .out_waddr   (alu_out_waddr),
    .out_wdata   (alu_out_wdata)
  );

  mul_unit #(
    .p_data_bits    (p_data_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) mul0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_val      (mul_in_val),
    .in_rdy      (mul_in_rdy),
    .in_seq_num  (d_seq_num),
    .in_op1      (d_op1),
    .in_op2      (d_op2),
    .in_waddr    (d_waddr),
    .out_val     (mul_out_val),
    .out_rdy     (mul_out_rdy),
    .out_seq_num (mul_out_seq_num),
    .out_waddr   (mul_out_waddr),
    .out_wdata   (mul_out_wdata)
  );

  wb_arbiter #(
    .p_data_bits    (p_data_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) arb0 (
    .clk             (clk),
    .arst_n          (arst_n),
    .alu_out_val     (alu_out_val),
    .alu_out_rdy     (alu_out_rdy),
    .alu_out_seq_num (alu_out_seq_num),
    .alu_out_waddr   (alu_out_waddr),
    .alu_out_wdata   (alu_out_wdata),
    .mul_out_val     (mul_out_val),
    .mul_out_rdy     (mul_out_rdy),
    .mul_out_seq_num (mul_out_seq_num),
    .mul_out_waddr   (mul_out_waddr),
    .mul_out_wdata   (mul_out_wdata),
    .w_val           (w_val),
    .w_rdy           (w_rdy),
    .w_seq_num       (w_seq_num),
    .w_waddr         (w_waddr),
    .w_wdata         (w_wdata),
    .w_wen           (w_wen)
  );

endmodule

/* design/mul_unit.sv */
// iterative shift-add multiplier
// one multiplier bit per cycle, returns the low half of the product
// p_data_bits+1 cycles after acceptance

`timescale 1ns/1ps

module mul_unit #(
  parameter int p_data_bits    = 32,
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      arst_n,

  // input side
  input  logic                      in_val,
  output logic                      in_rdy,
  input  logic [p_seq_num_bits-1:0] in_seq_num,
  input  logic [p_data_bits-1:0]    in_op1,
  input  logic [p_data_bits-1:0]    in_op2,
  input  logic [4:0]                in_waddr,

  // output side
  output logic                      out_val,
  input  logic                      out_rdy,
  output logic [p_seq_num_bits-1:0] out_seq_num,
  output logic [4:0]                out_waddr,
  output logic [p_data_bits-1:0]    out_wdata
);

  // step counter runs 0 .. p_data_bits-1
  localparam int step_bits = $clog2(p_data_bits);
  localparam logic [step_bits-1:0] last_step = step_bits'(p_data_bits - 1);

  logic                   busy;
  logic [step_bits-1:0]   step;
  logic [p_data_bits-1:0] mcand;
  logic [p_data_bits-1:0] mplier;
  logic [p_data_bits-1:0] acc;
  logic                   accept;

  // one op in flight, and nothing waiting at the output
  assign in_rdy = !busy && !out_val;
  assign accept = in_val && in_rdy;

  // ------------------------------------------------------------
  // control
  // ------------------------------------------------------------

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy    <= 1'b0;
      step    <= '0;
      out_val <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        busy <= 1'b1;
        step <= '0;
      end
      else if (busy)
      begin
        step <= step + 1'b1;
        // last add happens on this edge
        if (step == last_step)
        begin
          busy    <= 1'b0;
          out_val <= 1'b1;
        end
      end
      else if (out_val && out_rdy)
      begin
        out_val <= 1'b0;
      end
    end
  end

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      mcand       <= in_op1;
      mplier      <= in_op2;
      acc         <= '0;
      out_seq_num <= in_seq_num;
      out_waddr   <= in_waddr;
    end
    else if (busy)
    begin
      // add shifted multiplicand on a set multiplier bit
      if (mplier[0])
      begin
        acc <= acc + mcand;
      end
      // bits past the top fall off, keeping the low half only
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulator holds steady once busy drops
  assign out_wdata = acc;

endmodule

/* design/wb_arbiter.sv */
// round-robin writeback arbiter
// picks ALU or multiplier result for the W port, locks a grant that
// is stalled by w_rdy, forms wen so x0 is never written

`timescale 1ns/1ps

module wb_arbiter #(
  parameter int p_data_bits    = 32,
  parameter int p_seq_num_bits = 5
) (
  input  logic                      clk,
  input  logic                      arst_n,

  // ALU result
  input  logic                      alu_out_val,
  output logic                      alu_out_rdy,
  input  logic [p_seq_num_bits-1:0] alu_out_seq_num,
  input  logic [4:0]                alu_out_waddr,
  input  logic [p_data_bits-1:0]    alu_out_wdata,

  // multiplier result
  input  logic                      mul_out_val,
  output logic                      mul_out_rdy,
  input  logic [p_seq_num_bits-1:0] mul_out_seq_num,
  input  logic [4:0]                mul_out_waddr,
  input  logic [p_data_bits-1:0]    mul_out_wdata,

  // W side
  output logic                      w_val,
  input  logic                      w_rdy,
  output logic [p_seq_num_bits-1:0] w_seq_num,
  output logic [4:0]                w_waddr,
  output logic [p_data_bits-1:0]    w_wdata,
  output logic                      w_wen
);

  // last winner was the multiplier
  logic last_mul;
  // previous grant still pending
  logic locked;
  logic grant_mul;

  // stalled grant holds, else alternate on a tie
  always_comb
  begin
    if (locked)
      grant_mul = last_mul;
    else if (alu_out_val && mul_out_val)
      grant_mul = !last_mul;
    else
      grant_mul = mul_out_val;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      last_mul <= 1'b0;
      locked   <= 1'b0;
    end
    else
    begin
      if (w_val)
        last_mul <= grant_mul;
      locked <= w_val && !w_rdy;
    end
  end

  // ------------------------------------------------------------
  // W mux
  // ------------------------------------------------------------

  assign w_val     = grant_mul ? mul_out_val     : alu_out_val;
  assign w_seq_num = grant_mul ? mul_out_seq_num : alu_out_seq_num;
  assign w_waddr   = grant_mul ? mul_out_waddr   : alu_out_waddr;
  assign w_wdata   = grant_mul ? mul_out_wdata   : alu_out_wdata;

  // x0 stays zero
  assign w_wen = (w_waddr != 5'd0);

  // drain only the granted unit
  assign alu_out_rdy = w_rdy && !grant_mul;
  assign mul_out_rdy = w_rdy &&  grant_mul;

endmodule

/* dv/exec_asserts.sv */
// execute stage protocol checker
// W back-pressure stability, reset values and ALU latency

`timescale 1ns/1ps

module exec_asserts #(
  parameter int p_data_bits    = 32,
  parameter int p_seq_num_bits = 5
) (
  input logic                      clk,
  input logic                      arst_n,
  input logic                      d_rdy,
  input logic                      w_val,
  input logic                      w_rdy,
  input logic [p_seq_num_bits-1:0] w_seq_num,
  input logic [4:0]                w_waddr,
  input logic [p_data_bits-1:0]    w_wdata,
  input logic                      w_wen,
  input logic                      alu_in_val,
  input logic                      alu_in_rdy,
  input logic                      mul_out_val
);

  // failed checks so far
  int fail_count = 0;

  // stalled W keeps valid and payload
  w_hold_check: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && !w_rdy) |=> (w_val && $stable(w_seq_num) && $stable(w_waddr)
                           && $stable(w_wdata) && $stable(w_wen)))
  else
  begin
    fail_count++;
    $error("W bundle changed while stalled");
  end

  // first cycle out of reset
  reset_check: assert property (@(posedge clk)
    $rose(arst_n) |-> (!w_val && d_rdy))
  else
  begin
    fail_count++;
    $error("wrong w_val or d_rdy right after reset");
  end

  // ALU result shows on W one cycle after accept
  alu_latency_check: assert property (@(posedge clk) disable iff (!arst_n)
    (alu_in_val && alu_in_rdy && !mul_out_val) |=> w_val)
  else
  begin
    fail_count++;
    $error("ALU result missed its one-cycle slot on W");
  end

endmodule

/* dv/exec_tb.sv */
// execute stage testbench
// random micro-ops with edge operands and random W stalls, results
// checked by assertions against a table indexed by seq_num

`timescale 1ns/1ps

module exec_tb;

  import exec_pkg::*;

  localparam int          data_bits  = 32;
  localparam int          seq_bits   = 5;
  localparam int          num_slots  = 2**seq_bits;
  localparam int          num_ops    = 300;
  localparam int          wait_limit = 400;
  localparam logic [31:0] seed       = 32'hc51e_22e5;

  logic                 clk;
  logic                 arst_n;
  logic                 d_val;
  logic                 d_rdy;
  logic [seq_bits-1:0]  d_seq_num;
  logic [data_bits-1:0] d_op1;
  logic [data_bits-1:0] d_op2;
  logic [4:0]           d_waddr;
  rv_uop                d_uop;
  logic                 w_val;
  logic                 w_rdy;
  logic [seq_bits-1:0]  w_seq_num;
  logic [4:0]           w_waddr;
  logic [data_bits-1:0] w_wdata;
  logic                 w_wen;

  // expected result for each tag slot
  logic [data_bits-1:0] exp_wdata [num_slots];
  logic [4:0]           exp_waddr [num_slots];
  logic                 outstanding [num_slots];
  // send order of each tag
  int                   sent_idx [num_slots];

  // table entry picked by the tag on W
  logic [data_bits-1:0] cur_wdata;
  logic [4:0]           cur_waddr;
  logic                 cur_outstanding;

  logic                 mul_pending;
  logic [seq_bits-1:0]  mul_seq;
  int                   mul_idx;
  int                   ooo_count;
  int                   send_count;
  logic [31:0]          stim_state;
  logic [31:0]          rdy_state;

  exec_top #(
    .p_data_bits    (data_bits),
    .p_seq_num_bits (seq_bits)
  ) dut0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .d_val     (d_val),
    .d_rdy     (d_rdy),
    .d_seq_num (d_seq_num),
    .d_op1     (d_op1),
    .d_op2     (d_op2),
    .d_waddr   (d_waddr),
    .d_uop     (d_uop),
    .w_val     (w_val),
    .w_rdy     (w_rdy),
    .w_seq_num (w_seq_num),
    .w_waddr   (w_waddr),
    .w_wdata   (w_wdata),
    .w_wen     (w_wen)
  );

  // protocol checks ride along inside the DUT
  bind exec_top exec_asserts #(
    .p_data_bits    (p_data_bits),
    .p_seq_num_bits (p_seq_num_bits)
  ) asserts0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .d_rdy       (d_rdy),
    .w_val       (w_val),
    .w_rdy       (w_rdy),
    .w_seq_num   (w_seq_num),
    .w_waddr     (w_waddr),
    .w_wdata     (w_wdata),
    .w_wen       (w_wen),
    .alu_in_val  (alu_in_val),
    .alu_in_rdy  (alu_in_rdy),
    .mul_out_val (mul_out_val)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    begin
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
    end
  endfunction

  // reference result straight from the opcode rules
  function automatic logic [31:0] expected_result(input rv_uop uop, input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] fill;
    begin
      sh = b[4:0];
      // ones shifted in from the top for a negative op1
      fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
      case (uop)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_and:  return a & b;
        op_or:   return a | b;
        op_xor:  return a ^ b;
        op_sll:  return a << sh;
        op_srl:  return a >> sh;
        op_sra:  return (a >> sh) | fill;
        // flipping the sign bit turns signed order into unsigned order
        op_slt:  return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
        op_sltu: return {31'b0, a < b};
        op_lui:  return b;
        op_mul:  return a * b;
        default: return 32'h0;
      endcase
    end
  endfunction

  // edge values more often than plain random
  function automatic logic [31:0] pick_operand(input logic [31:0] r);
    case (r[2:0])
      3'd0:    return 32'h0;
      3'd1:    return 32'hffff_ffff;
      3'd2:    return 32'h8000_0000;
      3'd3:    return 32'h7fff_ffff;
      3'd4:    return {27'b0, r[12:8]};
      default: return {r[15:0], r[31:16]};
    endcase
  endfunction

  // roughly one multiply in four
  function automatic rv_uop pick_uop(input logic [31:0] r);
    if (r[1:0] == 2'b00)
      return op_mul;
    else
      return rv_uop'(4'(r[9:4] % 6'd11));
  endfunction

  function automatic int count_outstanding();
    int n;
    begin
      n = 0;
      for (int i = 0; i < num_slots; i++)
        n += outstanding[i];
      return n;
    end
  endfunction

  task automatic abort_run(input string why);
    begin
      $display("%s", why);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] got_val);
    begin
      $display("Fail %s exp %h got %h", name, exp_val, got_val);
      $display("TEST FAIL");
      $fatal(1);
    end
  endtask

  // ------------------------------------------------------------
  // D side driver
  // ------------------------------------------------------------

  task automatic send_uop(input logic [seq_bits-1:0] seq);
    rv_uop       uop;
    logic [31:0] a;
    logic [31:0] b;
    int          waited;
    begin
      // tag slot has to retire before reuse
      waited = 0;
      while (outstanding[seq])
      begin
        waited++;
        if (waited > wait_limit)
          abort_run("timed out waiting for a free seq_num slot");
        @(posedge clk);
        #1;
      end
      stim_state = xorshift32(stim_state);
      uop = pick_uop(stim_state);
      stim_state = xorshift32(stim_state);
      a = pick_operand(stim_state);
      stim_state = xorshift32(stim_state);
      b = pick_operand(stim_state);
      stim_state = xorshift32(stim_state);
      send_count++;
      exp_wdata[seq] = expected_result(uop, a, b);
      exp_waddr[seq] = stim_state[4:0];
      sent_idx[seq]  = send_count;
      d_val     = 1'b1;
      d_seq_num = seq;
      d_op1     = a;
      d_op2     = b;
      d_waddr   = stim_state[4:0];
      d_uop     = uop;
      // hold fields until the DUT takes them
      waited = 0;
      @(posedge clk);
      while (!d_rdy)
      begin
        waited++;
        if (waited > wait_limit)
          abort_run("timed out waiting for d_rdy");
        @(posedge clk);
      end
      #1;
      d_val = 1'b0;
      // occasional idle cycle
      if (stim_state[10:8] == 3'd0)
      begin
        @(posedge clk);
        #1;
      end
    end
  endtask

  // W sink stalls about one cycle in four
  initial
  begin
    w_rdy     = 1'b0;
    rdy_state = seed ^ 32'h5a5a_5a5a;
    forever
    begin
      @(posedge clk);
      #1;
      rdy_state = xorshift32(rdy_state);
      w_rdy = (rdy_state[1:0] != 2'b00);
    end
  end

  // ------------------------------------------------------------
  // scoreboard bookkeeping
  // ------------------------------------------------------------

  always @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      mul_pending <= 1'b0;
      mul_seq     <= '0;
      mul_idx     <= 0;
      ooo_count   <= 0;
      for (int i = 0; i < num_slots; i++)
        outstanding[i] <= 1'b0;
    end
    else
    begin
      if (w_val && w_rdy)
      begin
        outstanding[w_seq_num] <= 1'b0;
        // sent after the pending multiply but finished first
        if (mul_pending && sent_idx[w_seq_num] > mul_idx)
          ooo_count <= ooo_count + 1;
        if (mul_pending && w_seq_num == mul_seq)
          mul_pending <= 1'b0;
      end
      // tag in flight from its D handshake on
      if (d_val && d_rdy)
        outstanding[d_seq_num] <= 1'b1;
      if (d_val && d_rdy && d_uop == op_mul)
      begin
        mul_pending <= 1'b1;
        mul_seq     <= d_seq_num;
        mul_idx     <= sent_idx[d_seq_num];
      end
    end
  end

  assign cur_wdata       = exp_wdata[w_seq_num];
  assign cur_waddr       = exp_waddr[w_seq_num];
  assign cur_outstanding = outstanding[w_seq_num];

  // ------------------------------------------------------------
  // result checks at each W handshake
  // ------------------------------------------------------------

  wdata_check: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && w_rdy) |-> (w_wdata == cur_wdata))
  else
    report_mismatch("w_wdata", $sampled(cur_wdata), $sampled(w_wdata));

  waddr_check: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && w_rdy) |-> (w_waddr == cur_waddr))
  else
    report_mismatch("w_waddr", 32'($sampled(cur_waddr)), 32'($sampled(w_waddr)));

  // x0 never written
  wen_check: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && w_rdy) |-> (w_wen == (cur_waddr != 5'd0)))
  else
    report_mismatch("w_wen", 32'($sampled(cur_waddr) != 5'd0), 32'($sampled(w_wen)));

  inflight_check: assert property (@(posedge clk) disable iff (!arst_n)
    (w_val && w_rdy) |-> cur_outstanding)
  else
    abort_run("a result came back for a seq_num that was not in flight");

  // busy multiplier must refuse a second multiply
  mul_block_check: assert property (@(posedge clk) disable iff (!arst_n)
    (mul_pending && d_val && d_uop == op_mul) |-> !d_rdy)
  else
    abort_run("a multiply was accepted while the multiplier was busy");

  // protocol assertion failures counted inside the bound checker
  always @(negedge clk)
  begin
    if (dut0.asserts0.fail_count != 0)
      abort_run("a W protocol or latency assertion failed");
  end

  // ------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------

  initial
  begin
    int waited;
    arst_n     = 1'b0;
    d_val      = 1'b0;
    d_seq_num  = '0;
    d_op1      = '0;
    d_op2      = '0;
    d_waddr    = '0;
    d_uop      = op_add;
    stim_state = seed;
    send_count = 0;
    for (int i = 0; i < num_slots; i++)
    begin
      exp_wdata[i] = '0;
      exp_waddr[i] = '0;
      sent_idx[i]  = 0;
    end
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;

    for (int n = 0; n < num_ops; n++)
      send_uop(seq_bits'(n));

    // let every result drain out of W
    waited = 0;
    while (count_outstanding() != 0)
    begin
      waited++;
      if (waited > wait_limit)
        abort_run("timed out with results still outstanding");
      @(posedge clk);
      #1;
    end

    if (ooo_count == 0)
    begin
      $display("no ALU result ever finished ahead of a pending multiply");
      $display("TEST FAIL");
      $fatal(1);
    end
    else
    begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

/* sources.f */
design/exec_pkg.sv
design/exec_dispatch.sv
design/alu_unit.sv
design/mul_unit.sv
design/wb_arbiter.sv
design/exec_top.sv
dv/exec_asserts.sv
dv/exec_tb.sv
